// File: Makefile
# Verilator build and run for the data cache testbench

SIM      := verilator
FLAGS    := --binary --timing
TOP      := tb_dcache
FILELIST := build.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass or fail comes from the log, not the simulator exit code
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: build.f
common/dcache_pkg.sv
verilog/sync_ram.sv
dcache/dcache_line_state.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
verification/tb_mem_model.sv
verification/tb_dcache.sv

// File: common/dcache_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths, address split and types for the two-way data cache
// referenced by scoped name from the cache RTL and the testbench
//////////////////////////////////////////////////////////////////////
package dcache_pkg;

    // byte address and data word
    localparam int ADDR_W   = 64;
    localparam int WORD_W   = 64;
    localparam int OFFSET_W = 3;

    // 64 sets unless the top level says otherwise
    localparam int DEF_INDEX_W = 6;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // one enable per byte lane of a word
    typedef logic [WORD_W/8-1:0] mask_t;

    // tag is whatever remains above index and offset
    typedef logic [ADDR_W-DEF_INDEX_W-OFFSET_W-1:0] tag_t;

    // two ways, so a single bit names one
    typedef logic way_t;

    // controller FSM
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        WBCK   = 3'd2,
        REFILL = 3'd3,
        RESP   = 3'd4
    } ctrl_state_t;

endpackage

// File: dcache/dcache_ctrl.sv
//////////////////////////////////////////////////////////////////////
// cache controller FSM for loads and stores, with request capture,
// RAM write control and the memory-side write-back and refill strobes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dcache_ctrl #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_i,
    input  logic                wr_i,
    input  dcache_pkg::addr_t   addr_i,
    input  dcache_pkg::word_t   wdata_i,
    input  dcache_pkg::mask_t   mask_i,
    output dcache_pkg::word_t   rdata_o,
    output logic                done_o,
    input  logic                hit_i,
    input  dcache_pkg::way_t    hit_way_i,
    input  dcache_pkg::way_t    victim_way_i,
    input  logic                victim_valid_i,
    input  logic                victim_dirty_i,
    output logic                fill_o,
    output dcache_pkg::way_t    fill_way_o,
    output logic                fill_dirty_o,
    output logic                touch_o,
    output dcache_pkg::way_t    touch_way_o,
    output logic                set_dirty_o,
    output logic [INDEX_W-1:0]  ram_index_o,
    output logic [1:0]          tag_we_o,
    output logic [1:0]          data_we_o,
    output dcache_pkg::tag_t    tag_wdata_o,
    output dcache_pkg::word_t   data_wdata_o,
    input  dcache_pkg::tag_t    tag0_i,
    input  dcache_pkg::tag_t    tag1_i,
    input  dcache_pkg::word_t   word0_i,
    input  dcache_pkg::word_t   word1_i,
    output logic                mem_rd_o,
    output logic                mem_wr_o,
    output dcache_pkg::addr_t   mem_addr_o,
    output dcache_pkg::word_t   mem_wdata_o,
    input  dcache_pkg::word_t   mem_rdata_i,
    input  logic                mem_ok_i
);

    localparam int OFF_W = dcache_pkg::OFFSET_W;
    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - OFF_W;
    localparam int IDX_HI = INDEX_W + OFF_W - 1;

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;
    logic                    wr_q;
    logic                    hit_q;
    dcache_pkg::way_t        way_q;
    logic                    mem_rd_q;
    logic                    mem_wr_q;
    dcache_pkg::addr_t       req_addr_q;
    dcache_pkg::word_t       wdata_q;
    dcache_pkg::mask_t       mask_q;
    dcache_pkg::word_t       line_q;
    dcache_pkg::addr_t       mem_addr_q;
    dcache_pkg::word_t       mem_wdata_q;
    logic [INDEX_W-1:0]      req_index;
    dcache_pkg::word_t       hit_word;
    dcache_pkg::word_t       victim_word;
    dcache_pkg::tag_t        victim_tag;
    dcache_pkg::word_t       fill_word;
    logic                    need_wbck;
    logic                    refill_done;
    logic                    store_hit_wr;

    // replace the enabled byte lanes of old_w with those of new_w
    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
                                                      input dcache_pkg::word_t new_w,
                                                      input dcache_pkg::mask_t m);
        dcache_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < dcache_pkg::WORD_W / 8; b++) begin
            if (m[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign req_index   = req_addr_q[IDX_HI:OFF_W];
    assign hit_word    = hit_way_i ? word1_i : word0_i;
    assign victim_word = victim_way_i ? word1_i : word0_i;
    assign victim_tag  = victim_way_i ? tag1_i : tag0_i;
    assign need_wbck   = victim_valid_i && victim_dirty_i;
    // a store miss lands its bytes on top of the refilled word
    assign fill_word   = wr_q ? merge_bytes(mem_rdata_i, wdata_q, mask_q) : mem_rdata_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE:   if (rd_i || wr_i) state_d = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP: begin
                if (hit_i) begin
                    state_d = dcache_pkg::RESP;
                end else if (need_wbck) begin
                    state_d = dcache_pkg::WBCK;
                end else begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::WBCK:   if (mem_ok_i) state_d = dcache_pkg::REFILL;
            dcache_pkg::REFILL: if (mem_ok_i) state_d = dcache_pkg::RESP;
            default:            state_d = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q  <= dcache_pkg::IDLE;
            wr_q     <= 1'b0;
            hit_q    <= 1'b0;
            way_q    <= 1'b0;
            mem_rd_q <= 1'b0;
            mem_wr_q <= 1'b0;
        end else begin
            state_q <= state_d;
            case (state_q)
                dcache_pkg::IDLE:   wr_q <= wr_i;
                dcache_pkg::LOOKUP: begin
                    hit_q    <= hit_i;
                    way_q    <= hit_i ? hit_way_i : victim_way_i;
                    mem_wr_q <= !hit_i && need_wbck;
                    mem_rd_q <= !hit_i && !need_wbck;
                end
                dcache_pkg::WBCK: begin
                    // write-back accepted, go straight on to the refill read
                    if (mem_ok_i) begin
                        mem_wr_q <= 1'b0;
                        mem_rd_q <= 1'b1;
                    end
                end
                dcache_pkg::REFILL: if (mem_ok_i) mem_rd_q <= 1'b0;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            dcache_pkg::IDLE: begin
                req_addr_q <= addr_i;
                wdata_q    <= wdata_i;
                mask_q     <= mask_i;
            end
            dcache_pkg::LOOKUP: begin
                line_q      <= wr_q ? merge_bytes(hit_word, wdata_q, mask_q) : hit_word;
                mem_wdata_q <= victim_word;
                if (need_wbck) begin
                    mem_addr_q <= {victim_tag, req_index, {OFF_W{1'b0}}};
                end else begin
                    mem_addr_q <= {req_addr_q[dcache_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
                end
            end
            dcache_pkg::WBCK: begin
                if (mem_ok_i) begin
                    mem_addr_q <= {req_addr_q[dcache_pkg::ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
                end
            end
            dcache_pkg::REFILL: if (mem_ok_i) line_q <= fill_word;
            default: ;
        endcase
    end

    // RAMs look up the incoming index while still in IDLE
    assign ram_index_o  = (state_q == dcache_pkg::IDLE) ? addr_i[IDX_HI:OFF_W] : req_index;
    assign tag_wdata_o  = req_addr_q[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign refill_done  = (state_q == dcache_pkg::REFILL) && mem_ok_i;
    assign store_hit_wr = (state_q == dcache_pkg::RESP) && hit_q && wr_q;
    assign tag_we_o     = {refill_done && way_q, refill_done && !way_q};
    assign data_we_o    = {(refill_done || store_hit_wr) && way_q,
                           (refill_done || store_hit_wr) && !way_q};
    assign data_wdata_o = refill_done ? fill_word : line_q;

    assign fill_o       = refill_done;
    assign fill_way_o   = way_q;
    assign fill_dirty_o = wr_q;
    assign touch_o      = (state_q == dcache_pkg::RESP) && hit_q;
    assign touch_way_o  = way_q;
    assign set_dirty_o  = wr_q;

    assign rdata_o     = line_q;
    assign done_o      = (state_q == dcache_pkg::RESP);
    assign mem_rd_o    = mem_rd_q;
    assign mem_wr_o    = mem_wr_q;
    assign mem_addr_o  = mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;

endmodule

// File: dcache/dcache_line_state.sv
//////////////////////////////////////////////////////////////////////
// per-set valid, dirty and LRU bits with hit and victim selection
// tags come in from the tag RAMs, updates are strobed by the controller
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dcache_line_state #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [INDEX_W-1:0]  index_i,
    input  dcache_pkg::tag_t    req_tag_i,
    input  dcache_pkg::tag_t    tag0_i,
    input  dcache_pkg::tag_t    tag1_i,
    input  logic                fill_i,
    input  dcache_pkg::way_t    fill_way_i,
    input  logic                fill_dirty_i,
    input  logic                touch_i,
    input  dcache_pkg::way_t    touch_way_i,
    input  logic                set_dirty_i,
    output logic                hit_o,
    output dcache_pkg::way_t    hit_way_o,
    output dcache_pkg::way_t    victim_way_o,
    output logic                victim_valid_o,
    output logic                victim_dirty_o
);

    localparam int SETS = 1 << INDEX_W;

    logic [SETS-1:0] valid_q [2];
    logic [SETS-1:0] dirty_q [2];
    // lru_q holds the way used least recently
    logic [SETS-1:0] lru_q;
    logic            hit0;
    logic            hit1;

    assign hit0      = valid_q[0][index_i] && (tag0_i == req_tag_i);
    assign hit1      = valid_q[1][index_i] && (tag1_i == req_tag_i);
    assign hit_o     = hit0 || hit1;
    assign hit_way_o = hit1;

    // empty way first, way 0 before way 1, then LRU
    assign victim_way_o = !valid_q[0][index_i] ? 1'b0 :
                          !valid_q[1][index_i] ? 1'b1 : lru_q[index_i];
    assign victim_valid_o = valid_q[victim_way_o][index_i];
    assign victim_dirty_o = dirty_q[victim_way_o][index_i];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            if (fill_i) begin
                valid_q[fill_way_i][index_i] <= 1'b1;
                dirty_q[fill_way_i][index_i] <= fill_dirty_i;
                lru_q[index_i]               <= ~fill_way_i;
            end
            if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;
                if (set_dirty_i) begin
                    dirty_q[touch_way_i][index_i] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: dcache/dcache_top.sv
//////////////////////////////////////////////////////////////////////
// two-way write-back data cache between a CPU load/store port and
// a word-wide memory port; instantiate this as the cache
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module dcache_top #(
    parameter int INDEX_W = dcache_pkg::DEF_INDEX_W
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rd_i,
    input  logic                wr_i,
    input  dcache_pkg::addr_t   addr_i,
    input  dcache_pkg::word_t   wdata_i,
    input  dcache_pkg::mask_t   mask_i,
    output dcache_pkg::word_t   rdata_o,
    output logic                done_o,
    output logic                mem_rd_o,
    output logic                mem_wr_o,
    output dcache_pkg::addr_t   mem_addr_o,
    output dcache_pkg::word_t   mem_wdata_o,
    input  dcache_pkg::word_t   mem_rdata_i,
    input  logic                mem_ok_i
);

    logic [INDEX_W-1:0] ram_index;
    logic [1:0]         tag_we;
    logic [1:0]         data_we;
    dcache_pkg::tag_t   tag_wdata;
    dcache_pkg::word_t  data_wdata;
    dcache_pkg::tag_t   tag0;
    dcache_pkg::tag_t   tag1;
    dcache_pkg::word_t  word0;
    dcache_pkg::word_t  word1;
    logic               hit;
    dcache_pkg::way_t   hit_way;
    dcache_pkg::way_t   victim_way;
    logic               victim_valid;
    logic               victim_dirty;
    logic               fill;
    dcache_pkg::way_t   fill_way;
    logic               fill_dirty;
    logic               touch;
    dcache_pkg::way_t   touch_way;
    logic               set_dirty;

    // tag and data arrays, one pair per way
    sync_ram #(.DEPTH_W(INDEX_W), .entry_t(dcache_pkg::tag_t)) u_tag0 (
        .clk(clk), .addr_i(ram_index), .we_i(tag_we[0]), .wdata_i(tag_wdata), .rdata_o(tag0)
    );
    sync_ram #(.DEPTH_W(INDEX_W), .entry_t(dcache_pkg::tag_t)) u_tag1 (
        .clk(clk), .addr_i(ram_index), .we_i(tag_we[1]), .wdata_i(tag_wdata), .rdata_o(tag1)
    );
    sync_ram #(.DEPTH_W(INDEX_W), .entry_t(dcache_pkg::word_t)) u_data0 (
        .clk(clk), .addr_i(ram_index), .we_i(data_we[0]), .wdata_i(data_wdata), .rdata_o(word0)
    );
    sync_ram #(.DEPTH_W(INDEX_W), .entry_t(dcache_pkg::word_t)) u_data1 (
        .clk(clk), .addr_i(ram_index), .we_i(data_we[1]), .wdata_i(data_wdata), .rdata_o(word1)
    );

    // the tag written on refill is the request tag, reused for compare
    dcache_line_state #(.INDEX_W(INDEX_W)) u_line_state (
        .clk(clk), .rst(rst), .index_i(ram_index), .req_tag_i(tag_wdata),
        .tag0_i(tag0), .tag1_i(tag1),
        .fill_i(fill), .fill_way_i(fill_way), .fill_dirty_i(fill_dirty),
        .touch_i(touch), .touch_way_i(touch_way), .set_dirty_i(set_dirty),
        .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way),
        .victim_valid_o(victim_valid), .victim_dirty_o(victim_dirty)
    );

    dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .clk(clk), .rst(rst), .rd_i(rd_i), .wr_i(wr_i), .addr_i(addr_i),
        .wdata_i(wdata_i), .mask_i(mask_i), .rdata_o(rdata_o), .done_o(done_o),
        .hit_i(hit), .hit_way_i(hit_way), .victim_way_i(victim_way),
        .victim_valid_i(victim_valid), .victim_dirty_i(victim_dirty),
        .fill_o(fill), .fill_way_o(fill_way), .fill_dirty_o(fill_dirty),
        .touch_o(touch), .touch_way_o(touch_way), .set_dirty_o(set_dirty),
        .ram_index_o(ram_index), .tag_we_o(tag_we), .data_we_o(data_we),
        .tag_wdata_o(tag_wdata), .data_wdata_o(data_wdata),
        .tag0_i(tag0), .tag1_i(tag1), .word0_i(word0), .word1_i(word1),
        .mem_rd_o(mem_rd_o), .mem_wr_o(mem_wr_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i), .mem_ok_i(mem_ok_i)
    );

endmodule

// File: verification/tb_dcache.sv
//////////////////////////////////////////////////////////////////////
// testbench for the two-way data cache with directed load/store tests
// and random traffic, checked against a shadow memory of the CPU view
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_dcache;

    localparam int RST_CYCLES = 16;
    localparam int N_DIRECTED = 12;
    localparam int N_RAND     = 40;
    // lookup, write-back, refill, response and the idle gap
    localparam int MISS_CYCLES = 12;
    localparam int MAX_CYCLES  = RST_CYCLES + (N_DIRECTED + N_RAND) * MISS_CYCLES + 20;
    localparam dcache_pkg::word_t PAT_MUL = 64'h9e37_79b9_7f4a_7c15;
    localparam dcache_pkg::word_t PAT_XOR = 64'h0f1e_2d3c_4b5a_6978;

    logic               clk;
    logic               rst;
    logic               rd;
    logic               wr;
    dcache_pkg::addr_t  addr;
    dcache_pkg::word_t  wdata;
    dcache_pkg::mask_t  mask;
    dcache_pkg::word_t  rdata;
    logic               done;
    logic               mem_rd;
    logic               mem_wr;
    dcache_pkg::addr_t  mem_addr;
    dcache_pkg::word_t  mem_wdata;
    dcache_pkg::word_t  mem_rdata;
    logic               mem_ok;
    logic [31:0]        rd_count;
    logic [31:0]        wr_count;
    dcache_pkg::addr_t  last_rd_addr;
    dcache_pkg::addr_t  last_wr_addr;
    dcache_pkg::word_t  last_wr_data;

    // expected contents as the CPU sees them
    dcache_pkg::word_t  shadow [dcache_pkg::addr_t];
    int                 errors;
    int                 tests;
    int                 cycles;
    int                 last_lat;
    logic [31:0]        lcg_state;

    dcache_top i_dcache_top (
        .clk(clk), .rst(rst), .rd_i(rd), .wr_i(wr), .addr_i(addr),
        .wdata_i(wdata), .mask_i(mask), .rdata_o(rdata), .done_o(done),
        .mem_rd_o(mem_rd), .mem_wr_o(mem_wr), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata), .mem_ok_i(mem_ok)
    );

    tb_mem_model #(.DELAY(3), .PAT_MUL(PAT_MUL), .PAT_XOR(PAT_XOR)) u_mem (
        .clk(clk), .rst(rst), .rd_i(mem_rd), .wr_i(mem_wr), .addr_i(mem_addr),
        .wdata_i(mem_wdata), .rdata_o(mem_rdata), .ok_o(mem_ok),
        .rd_count_o(rd_count), .wr_count_o(wr_count), .last_rd_addr_o(last_rd_addr),
        .last_wr_addr_o(last_wr_addr), .last_wr_data_o(last_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles, controller in state %s",
                     MAX_CYCLES, i_dcache_top.u_ctrl.state_q.name());
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input dcache_pkg::tag_t t,
                                                    input logic [5:0] idx);
        return {t, idx, 3'b000};
    endfunction

    // untouched words hold the memory fill pattern
    function automatic dcache_pkg::word_t expect_word(input dcache_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return (a * PAT_MUL) ^ PAT_XOR;
    endfunction

    function automatic dcache_pkg::word_t apply_mask(input dcache_pkg::word_t old_w,
                                                     input dcache_pkg::word_t new_w,
                                                     input dcache_pkg::mask_t m);
        dcache_pkg::word_t lanes;
        for (int b = 0; b < 8; b++) begin
            lanes[8*b +: 8] = {8{m[b]}};
        end
        return (old_w & ~lanes) | (new_w & lanes);
    endfunction

    task automatic check_word(input dcache_pkg::word_t got, input dcache_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input dcache_pkg::addr_t got, input dcache_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // one request, held until done; called on a falling edge
    task automatic access(input logic is_wr, input dcache_pkg::addr_t a,
                          input dcache_pkg::word_t d, input dcache_pkg::mask_t m,
                          output dcache_pkg::word_t q);
        rd       = !is_wr;
        wr       = is_wr;
        addr     = a;
        wdata    = d;
        mask     = m;
        last_lat = 0;
        do begin
            @(negedge clk);
            last_lat++;
        end while (done !== 1'b1);
        q  = rdata;
        rd = 1'b0;
        wr = 1'b0;
        @(negedge clk);
        check_bit(done, 1'b0, "done high for one cycle only");
    endtask

    task automatic load_check(input dcache_pkg::addr_t a, input string what);
        dcache_pkg::word_t q;
        access(1'b0, a, '0, '0, q);
        check_word(q, expect_word(a), what);
    endtask

    task automatic store(input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
                         input dcache_pkg::mask_t m);
        dcache_pkg::word_t q;
        access(1'b1, a, d, m, q);
        shadow[a] = apply_mask(expect_word(a), d, m);
    endtask

    task automatic finish_test(input string name, input int e0);
        tests++;
        $display("%s: %0d errors", name, errors - e0);
    endtask

    task automatic first_load();
        dcache_pkg::addr_t a;
        logic [31:0]       r0;
        int                e0;
        e0 = errors;
        a  = make_addr(55'h12, 6'd1);
        check_bit(done, 1'b0, "done after reset");
        check_bit(mem_rd, 1'b0, "mem_rd after reset");
        check_bit(mem_wr, 1'b0, "mem_wr after reset");
        r0 = rd_count;
        load_check(a, "first load data");
        check_bit(rd_count == r0 + 32'd1, 1'b1, "one refill read");
        check_addr(last_rd_addr, a, "refill address");
        check_bit(wr_count == 32'd0, 1'b1, "no write on first load");
        finish_test("first load", e0);
    endtask

    task automatic repeat_load();
        dcache_pkg::addr_t a;
        logic [31:0]       r0;
        int                e0;
        e0 = errors;
        a  = make_addr(55'h12, 6'd1);
        r0 = rd_count;
        load_check(a, "load hit data");
        check_bit(last_lat == 2, 1'b1, "hit latency of 2 cycles");
        check_bit(rd_count == r0, 1'b1, "no memory read on hit");
        finish_test("load hit", e0);
    endtask

    task automatic store_hit();
        dcache_pkg::addr_t a;
        logic [31:0]       r0;
        logic [31:0]       w0;
        int                e0;
        e0 = errors;
        a  = make_addr(55'h12, 6'd1);
        r0 = rd_count;
        w0 = wr_count;
        store(a, 64'hdead_beef_cafe_f00d, 8'b0101_0010);
        load_check(a, "load after partial store hit");
        check_bit(rd_count == r0 && wr_count == w0, 1'b1, "no memory access on store hit");
        finish_test("store hit", e0);
    endtask

    task automatic store_miss();
        dcache_pkg::addr_t a;
        logic [31:0]       r0;
        logic [31:0]       w0;
        int                e0;
        e0 = errors;
        a  = make_addr(55'h340, 6'd2);
        r0 = rd_count;
        w0 = wr_count;
        store(a, 64'h0123_4567_89ab_cdef, 8'h0f);
        check_bit(rd_count == r0 + 32'd1, 1'b1, "one refill read on store miss");
        check_bit(wr_count == w0, 1'b1, "no write-back into an empty set");
        load_check(a, "load after store miss");
        check_bit(rd_count == r0 + 32'd1, 1'b1, "load after store miss hits");
        finish_test("store miss", e0);
    endtask

    task automatic eviction_order();
        dcache_pkg::addr_t x;
        dcache_pkg::addr_t y;
        dcache_pkg::addr_t z;
        logic [31:0]       r0;
        logic [31:0]       w0;
        int                e0;
        e0 = errors;
        x  = make_addr(55'h0a01, 6'd5);
        y  = make_addr(55'h0a02, 6'd5);
        z  = make_addr(55'h0a03, 6'd5);
        store(x, 64'h1111_2222_3333_4444, 8'hff);
        store(y, 64'h5555_6666_7777_8888, 8'h3c);
        // touching x leaves y least recently used
        load_check(x, "reload of first address");
        r0 = rd_count;
        w0 = wr_count;
        load_check(z, "load of third address");
        check_bit(wr_count == w0 + 32'd1, 1'b1, "one write-back on dirty eviction");
        check_addr(last_wr_addr, y, "write-back address");
        check_word(last_wr_data, expect_word(y), "write-back data");
        check_bit(rd_count == r0 + 32'd1, 1'b1, "one refill after write-back");
        // z is clean; touching x makes z the next victim
        r0 = rd_count;
        load_check(x, "first address still cached");
        check_bit(rd_count == r0, 1'b1, "no refill for first address");
        w0 = wr_count;
        load_check(y, "reload of evicted address");
        check_bit(rd_count == r0 + 32'd1, 1'b1, "one refill for evicted address");
        check_bit(wr_count == w0, 1'b1, "no write-back for clean victim");
        finish_test("eviction order", e0);
    endtask

    task automatic random_traffic();
        logic [31:0]       r;
        dcache_pkg::addr_t a;
        dcache_pkg::word_t d;
        int                e0;
        e0 = errors;
        for (int i = 0; i < N_RAND; i++) begin
            r = lcg_next();
            // four tags over four sets forces evictions
            a = make_addr(dcache_pkg::tag_t'(r[29:28]) + 55'h100, 6'd16 + 6'(r[27:26]));
            if (r[31]) begin
                d[63:32] = lcg_next();
                d[31:0]  = lcg_next();
                store(a, d, r[23:16]);
            end else begin
                load_check(a, "random load");
            end
        end
        finish_test("random traffic", e0);
    endtask

    initial begin
        rst       = 1'b0;
        rd        = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        wdata     = '0;
        mask      = '0;
        errors    = 0;
        tests     = 0;
        last_lat  = 0;
        lcg_state = 32'd35659;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        first_load();
        repeat_load();
        store_hit();
        store_miss();
        eviction_order();
        random_traffic();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verification/tb_mem_model.sv
//////////////////////////////////////////////////////////////////////
// behavioural word memory for the cache testbench, answers after DELAY
// cycles and reports access counts and the last addresses it saw
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_mem_model #(
    parameter int                DELAY   = 3,
    parameter dcache_pkg::word_t PAT_MUL = 64'h9e37_79b9_7f4a_7c15,
    parameter dcache_pkg::word_t PAT_XOR = 64'h0f1e_2d3c_4b5a_6978
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_i,
    input  logic               wr_i,
    input  dcache_pkg::addr_t  addr_i,
    input  dcache_pkg::word_t  wdata_i,
    output dcache_pkg::word_t  rdata_o,
    output logic               ok_o,
    output logic [31:0]        rd_count_o,
    output logic [31:0]        wr_count_o,
    output dcache_pkg::addr_t  last_rd_addr_o,
    output dcache_pkg::addr_t  last_wr_addr_o,
    output dcache_pkg::word_t  last_wr_data_o
);

    // only written words are stored, the rest follow the fill pattern
    dcache_pkg::word_t mem [dcache_pkg::addr_t];
    int                wait_cnt;

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            ok_o           <= 1'b0;
            rdata_o        <= '0;
            wait_cnt       <= 0;
            rd_count_o     <= '0;
            wr_count_o     <= '0;
            last_rd_addr_o <= '0;
            last_wr_addr_o <= '0;
            last_wr_data_o <= '0;
        end else if (ok_o) begin
            // the cache drops or changes its request on this edge
            ok_o     <= 1'b0;
            wait_cnt <= 0;
        end else if (rd_i || wr_i) begin
            if (wait_cnt == DELAY - 1) begin
                ok_o     <= 1'b1;
                wait_cnt <= 0;
                if (wr_i) begin
                    mem[addr_i] = wdata_i;
                    wr_count_o     <= wr_count_o + 32'd1;
                    last_wr_addr_o <= addr_i;
                    last_wr_data_o <= wdata_i;
                end else begin
                    rdata_o        <= mem.exists(addr_i) ? mem[addr_i] :
                                      ((addr_i * PAT_MUL) ^ PAT_XOR);
                    rd_count_o     <= rd_count_o + 32'd1;
                    last_rd_addr_o <= addr_i;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

// File: verilog/sync_ram.sv
//////////////////////////////////////////////////////////////////////
// single-port RAM with registered read and a typed entry
// serves as tag array or data array depending on entry_t
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module sync_ram #(
    parameter int  DEPTH_W = 6,
    parameter type entry_t = logic [63:0]
) (
    input  logic               clk,
    input  logic [DEPTH_W-1:0] addr_i,
    input  logic               we_i,
    input  entry_t             wdata_i,
    output entry_t             rdata_o
);

    localparam int DEPTH = 1 << DEPTH_W;

    entry_t mem [DEPTH];

    // write and read share the address
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // read-first, so a write shows up on the following read
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule
